// File: include/fb_macros.svh
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// screen size in pixels
`define FB_HRES 32
`define FB_VRES 16

// total pixel count, one depth and one colour entry each
`define FB_NPIX (`FB_HRES * `FB_VRES)

// depth word width
`define FB_DEPTH_W 16

// rgb565 pixels packed into one stream chunk
`define FB_PIX_PER_CHUNK 8

// read latency of depth and colour memories
// registered address plus registered output
`define FB_RD_LAT 2

`endif

// File: logic/color_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_macros.svh"

module color_ram
  import fb_geometry_pkg::*;
  import fb_pixel_pkg::*;
(
  input  logic      clk_in,
  input  logic      we,
  input  logic      write_bank,
  input  pix_addr_t waddr,
  input  rgb565_t   wdata,
  input  logic      read_bank,
  input  pix_addr_t raddr,
  output rgb565_t   rdata
);

  // bank bit on top of the pixel address
  localparam int BANK_ADDR_W = $bits(pix_addr_t) + 1;

  // both banks in one array
  rgb565_t mem [2*`FB_NPIX];

  logic [BANK_ADDR_W-1:0] raddr_q;

  // write port, the renderer side
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[{write_bank, waddr}] <= wdata;
    end
  end

  // read port, the scanout side
  // same two cycle shape as depth memory
  always_ff @(posedge clk_in) begin
    raddr_q <= {read_bank, raddr};
    rdata   <= mem[raddr_q];
  end

  // renderer and scanout never touch the same entry in one cycle
  // would mean a swap while a scan is still running
  a_no_bank_collision : assert property (
    @(posedge clk_in) we |-> ((write_bank != read_bank) || (waddr != raddr))
  ) else $error("colour write hits the entry being scanned, addr %0d", waddr);

endmodule

`default_nettype wire

// File: logic/depth_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_macros.svh"

module depth_ram
  import fb_geometry_pkg::*;
(
  input  logic      clk_in,
  input  logic      we,
  input  pix_addr_t waddr,
  input  depth_t    wdata,
  input  pix_addr_t raddr,
  output depth_t    rdata
);

  // one depth word per pixel
  depth_t    mem [`FB_NPIX];

  // read address register, first cycle of latency
  pix_addr_t raddr_q;

  // write port
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read port
  // address registered, then output registered
  // a write at the address edge is visible, one at the next edge is not
  always_ff @(posedge clk_in) begin
    raddr_q <= raddr;
    rdata   <= mem[raddr_q];
  end

  // writes stay inside the visible screen
  a_waddr_range : assert property (
    @(posedge clk_in) we |-> (int'(waddr) < `FB_NPIX)
  ) else $error("depth write outside the screen, addr %0d", waddr);

endmodule

`default_nettype wire

// File: logic/fb_geometry_pkg.sv
`default_nettype none

`include "fb_macros.svh"

package fb_geometry_pkg;

  // screen coordinates
  typedef logic [$clog2(`FB_HRES)-1:0] coord_x_t;
  typedef logic [$clog2(`FB_VRES)-1:0] coord_y_t;

  // linear pixel address, x + hres * y
  typedef logic [$clog2(`FB_NPIX)-1:0] pix_addr_t;

  // smaller is closer, all ones is far plane
  typedef logic [`FB_DEPTH_W-1:0] depth_t;

  // depth clear sweep after frame swap or reset
  typedef enum logic [1:0] {
    SWEEP_IDLE,
    SWEEP_DRAIN,
    SWEEP_CLEAR
  } sweep_state_t;

endpackage

`default_nettype wire

// File: logic/fb_pixel_pkg.sv
`default_nettype none

`include "fb_macros.svh"

package fb_pixel_pkg;

  // 5 bits red, 6 green, 5 blue
  typedef logic [15:0] rgb565_t;

  // stream word, pixel i in bits 16i+15 .. 16i
  typedef logic [`FB_PIX_PER_CHUNK*$bits(rgb565_t)-1:0] chunk_t;

  // scanout sequencing
  // read issues eight reads, hold waits for the transfer
  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_READ,
    SCAN_HOLD
  } scan_state_t;

endpackage

`default_nettype wire

// File: logic/frame_scanout.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_macros.svh"

module frame_scanout
  import fb_geometry_pkg::*;
  import fb_pixel_pkg::*;
(
  input  logic      clk_in,
  input  logic      arst_n,
  input  logic      scan_start,
  input  logic      display_bank,
  output pix_addr_t color_raddr,
  output logic      read_bank,
  input  rgb565_t   color_rdata,
  output logic      chunk_tvalid,
  output chunk_t    chunk_tdata,
  output logic      chunk_tlast,
  input  logic      chunk_tready
);

  localparam int PPC         = `FB_PIX_PER_CHUNK;
  localparam int NCHUNK      = `FB_NPIX / `FB_PIX_PER_CHUNK;
  localparam int ISSUE_W     = $clog2(PPC) + 1;
  localparam int RET_W       = $clog2(PPC);
  localparam int CHUNK_IDX_W = $clog2(NCHUNK);

  scan_state_t            scan_state;
  logic                   bank_q;
  pix_addr_t              rd_addr;
  logic [ISSUE_W-1:0]     issue_cnt;
  logic [RET_W-1:0]       ret_cnt;
  logic [CHUNK_IDX_W-1:0] chunk_idx;

  // one bit per read still inside the colour memory
  logic [`FB_RD_LAT-1:0] inflight;

  logic issue;
  logic ret;
  logic xfer;

  // eight reads per chunk, then stop until it leaves
  assign issue = (scan_state == SCAN_READ) && (issue_cnt < ISSUE_W'(PPC));
  assign ret   = inflight[`FB_RD_LAT-1];
  assign xfer  = chunk_tvalid && chunk_tready;

  assign color_raddr = rd_addr;
  // idle follows the display bank, a scan keeps the latched one
  assign read_bank   = (scan_state == SCAN_IDLE) ? display_bank : bank_q;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      scan_state   <= SCAN_IDLE;
      bank_q       <= 1'b0;
      rd_addr      <= '0;
      issue_cnt    <= '0;
      ret_cnt      <= '0;
      chunk_idx    <= '0;
      inflight     <= '0;
      chunk_tvalid <= 1'b0;
      chunk_tlast  <= 1'b0;
    end else begin
      inflight <= {inflight[`FB_RD_LAT-2:0], issue};
      if (issue) begin
        rd_addr   <= rd_addr + 1'b1;
        issue_cnt <= issue_cnt + 1'b1;
      end
      // wraps back to zero after a full chunk
      if (ret) begin
        ret_cnt <= ret_cnt + 1'b1;
      end
      case (scan_state)
        SCAN_IDLE: begin
          if (scan_start) begin
            bank_q     <= display_bank;
            rd_addr    <= '0;
            issue_cnt  <= '0;
            chunk_idx  <= '0;
            scan_state <= SCAN_READ;
          end
        end
        SCAN_READ: begin
          // eighth pixel lands this edge
          if (ret && (ret_cnt == RET_W'(PPC - 1))) begin
            chunk_tvalid <= 1'b1;
            chunk_tlast  <= (chunk_idx == CHUNK_IDX_W'(NCHUNK - 1));
            scan_state   <= SCAN_HOLD;
          end
        end
        SCAN_HOLD: begin
          // address counter parked, chunk held until taken
          if (xfer) begin
            chunk_tvalid <= 1'b0;
            chunk_tlast  <= 1'b0;
            chunk_idx    <= chunk_idx + 1'b1;
            issue_cnt    <= '0;
            scan_state   <= chunk_tlast ? SCAN_IDLE : SCAN_READ;
          end
        end
        default: begin
          scan_state <= SCAN_IDLE;
        end
      endcase
    end
  end

  // shift in from the top
  // first pixel of the group ends in the low bits
  always_ff @(posedge clk_in) begin
    if (ret) begin
      chunk_tdata <= {color_rdata, chunk_tdata[$bits(chunk_t)-1:$bits(rgb565_t)]};
    end
  end

  // stream rule, data frozen while stalled
  a_chunk_stable : assert property (
    @(posedge clk_in) disable iff (!arst_n)
    (chunk_tvalid && !chunk_tready) |=> (chunk_tvalid && $stable(chunk_tdata))
  ) else $error("chunk_tdata changed under back-pressure");

endmodule

`default_nettype wire

// File: logic/framebuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_macros.svh"

module framebuffer
  import fb_geometry_pkg::*;
  import fb_pixel_pkg::*;
(
  input  logic      clk_in,
  input  logic      arst_n,
  input  logic      valid_in,
  input  coord_x_t  x,
  input  coord_y_t  y,
  input  depth_t    z,
  input  rgb565_t   rgb_in,
  input  logic      frame_done,
  output logic      rdy_out,
  output logic      color_we,
  output pix_addr_t color_waddr,
  output rgb565_t   color_wdata,
  output logic      write_bank,
  output logic      display_bank
);

  // pipeline bundle is valid, address, z, colour
  localparam int PIPE_W    = 1 + $bits(pix_addr_t) + $bits(depth_t) + $bits(rgb565_t);
  localparam int DRAIN_W   = ($clog2(`FB_RD_LAT) > 0) ? $clog2(`FB_RD_LAT) : 1;
  localparam pix_addr_t LAST_ADDR = pix_addr_t'(`FB_NPIX - 1);

  sweep_state_t       sweep_state;
  pix_addr_t          clear_addr;
  logic [DRAIN_W-1:0] drain_cnt;

  logic              accept;
  pix_addr_t         pix_addr;
  logic [PIPE_W-1:0] pipe_in;
  logic [PIPE_W-1:0] pipe_out;

  // pixel as it meets its stored depth
  logic      d_valid;
  pix_addr_t d_addr;
  depth_t    d_z;
  rgb565_t   d_rgb;

  depth_t ram_depth;
  depth_t stored_depth;
  logic   pix_we;

  // muxed depth write port
  logic      depth_we;
  pix_addr_t depth_waddr;
  depth_t    depth_wdata;

  // last two depth writes, 0 is newest
  logic      fwd0_vld;
  logic      fwd1_vld;
  pix_addr_t fwd0_addr;
  pix_addr_t fwd1_addr;
  depth_t    fwd0_data;
  depth_t    fwd1_data;

  // only take pixels while no sweep is running
  assign rdy_out = (sweep_state == SWEEP_IDLE);
  assign accept  = valid_in && rdy_out;

  // linear address
  assign pix_addr = pix_addr_t'(x) + pix_addr_t'(`FB_HRES) * pix_addr_t'(y);

  // pixel rides alongside the depth read
  assign pipe_in = {accept, pix_addr, z, rgb_in};

  pixel_delay_line #(
    .STAGES (`FB_RD_LAT),
    .WIDTH  (PIPE_W)
  ) u_pixel_delay_line (
    .clk_in   (clk_in),
    .arst_n   (arst_n),
    .data     (pipe_in),
    .data_out (pipe_out)
  );

  assign {d_valid, d_addr, d_z, d_rgb} = pipe_out;

  // read issued the same edge the pixel is accepted
  depth_ram u_depth_ram (
    .clk_in (clk_in),
    .we     (depth_we),
    .waddr  (depth_waddr),
    .wdata  (depth_wdata),
    .raddr  (pix_addr),
    .rdata  (ram_depth)
  );

  // forwarding, newest write wins
  // covers back to back pixels at one address
  always_comb begin
    stored_depth = ram_depth;
    if (fwd1_vld && (fwd1_addr == d_addr)) begin
      stored_depth = fwd1_data;
    end
    if (fwd0_vld && (fwd0_addr == d_addr)) begin
      stored_depth = fwd0_data;
    end
  end

  // closer or equal passes, ties go to the later pixel
  assign pix_we = d_valid && (d_z <= stored_depth);

  // sweep owns the depth port while clearing
  assign depth_we    = (sweep_state == SWEEP_CLEAR) ? 1'b1       : pix_we;
  assign depth_waddr = (sweep_state == SWEEP_CLEAR) ? clear_addr : d_addr;
  assign depth_wdata = (sweep_state == SWEEP_CLEAR) ? '1         : d_z;

  assign color_we     = pix_we;
  assign color_waddr  = d_addr;
  assign color_wdata  = d_rgb;
  assign display_bank = ~write_bank;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      fwd0_vld <= 1'b0;
      fwd1_vld <= 1'b0;
    end else begin
      fwd0_vld <= depth_we;
      fwd1_vld <= fwd0_vld;
    end
  end

  always_ff @(posedge clk_in) begin
    fwd0_addr <= depth_waddr;
    fwd0_data <= depth_wdata;
    fwd1_addr <= fwd0_addr;
    fwd1_data <= fwd0_data;
  end

  // drain in-flight pixels, swap, then clear depth
  // reset starts straight in the clear
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      sweep_state <= SWEEP_CLEAR;
      clear_addr  <= '0;
      drain_cnt   <= '0;
      write_bank  <= 1'b0;
    end else begin
      case (sweep_state)
        SWEEP_IDLE: begin
          if (frame_done) begin
            drain_cnt   <= '0;
            sweep_state <= SWEEP_DRAIN;
          end
        end
        SWEEP_DRAIN: begin
          // last in-flight pixel writes this edge, still to the old bank
          if (drain_cnt == DRAIN_W'(`FB_RD_LAT - 1)) begin
            write_bank  <= ~write_bank;
            clear_addr  <= '0;
            sweep_state <= SWEEP_CLEAR;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        SWEEP_CLEAR: begin
          clear_addr <= clear_addr + 1'b1;
          if (clear_addr == LAST_ADDR) begin
            sweep_state <= SWEEP_IDLE;
          end
        end
        default: begin
          sweep_state <= SWEEP_IDLE;
        end
      endcase
    end
  end

  // drain must have emptied the pipeline before the clear
  a_no_pixel_in_clear : assert property (
    @(posedge clk_in) disable iff (!arst_n)
    (sweep_state == SWEEP_CLEAR) |-> !pix_we
  ) else $error("pixel write during depth clear, addr %0d", d_addr);

endmodule

`default_nettype wire

// File: logic/framebuffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_top
  import fb_geometry_pkg::*;
  import fb_pixel_pkg::*;
(
  input  logic     clk_in,
  input  logic     arst_n,
  input  logic     valid_in,
  input  coord_x_t x,
  input  coord_y_t y,
  input  depth_t   z,
  input  rgb565_t  rgb_in,
  input  logic     frame_done,
  output logic     rdy_out,
  input  logic     scan_start,
  output logic     chunk_tvalid,
  output chunk_t   chunk_tdata,
  output logic     chunk_tlast,
  input  logic     chunk_tready
);

  // renderer to colour memory
  logic      color_we;
  pix_addr_t color_waddr;
  rgb565_t   color_wdata;
  logic      write_bank;

  // scanout side
  logic      display_bank;
  pix_addr_t color_raddr;
  logic      read_bank;
  rgb565_t   color_rdata;

  framebuffer u_framebuffer (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .valid_in     (valid_in),
    .x            (x),
    .y            (y),
    .z            (z),
    .rgb_in       (rgb_in),
    .frame_done   (frame_done),
    .rdy_out      (rdy_out),
    .color_we     (color_we),
    .color_waddr  (color_waddr),
    .color_wdata  (color_wdata),
    .write_bank   (write_bank),
    .display_bank (display_bank)
  );

  color_ram u_color_ram (
    .clk_in     (clk_in),
    .we         (color_we),
    .write_bank (write_bank),
    .waddr      (color_waddr),
    .wdata      (color_wdata),
    .read_bank  (read_bank),
    .raddr      (color_raddr),
    .rdata      (color_rdata)
  );

  frame_scanout u_frame_scanout (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .scan_start   (scan_start),
    .display_bank (display_bank),
    .color_raddr  (color_raddr),
    .read_bank    (read_bank),
    .color_rdata  (color_rdata),
    .chunk_tvalid (chunk_tvalid),
    .chunk_tdata  (chunk_tdata),
    .chunk_tlast  (chunk_tlast),
    .chunk_tready (chunk_tready)
  );

endmodule

`default_nettype wire

// File: logic/pixel_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_delay_line #(
  parameter int STAGES = 2,
  parameter int WIDTH  = 8
) (
  input  logic             clk_in,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] data,
  output logic [WIDTH-1:0] data_out
);

  // msb of the bundle is the valid flag
  // remaining bits are payload
  logic             valid_q   [STAGES];
  logic [WIDTH-2:0] payload_q [STAGES];

  // only the valid chain sees reset
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < STAGES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= data[WIDTH-1];
      for (int i = 1; i < STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // payload shift, no reset
  always_ff @(posedge clk_in) begin
    payload_q[0] <= data[WIDTH-2:0];
    for (int i = 1; i < STAGES; i++) begin
      payload_q[i] <= payload_q[i-1];
    end
  end

  assign data_out = {valid_q[STAGES-1], payload_q[STAGES-1]};

endmodule

`default_nettype wire

// File: project.f
+incdir+include
logic/fb_geometry_pkg.sv
logic/fb_pixel_pkg.sv
logic/pixel_delay_line.sv
logic/depth_ram.sv
logic/color_ram.sv
logic/framebuffer.sv
logic/frame_scanout.sv
logic/framebuffer_top.sv
verification/framebuffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the framebuffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module framebuffer_tb -o framebuffer_sim \
  && ./obj_dir/framebuffer_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log

grep -q "Test completed successfully" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// File: verification/framebuffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_macros.svh"

module framebuffer_tb
  import fb_geometry_pkg::*;
  import fb_pixel_pkg::*;
();

  localparam int NCHUNK          = `FB_NPIX / `FB_PIX_PER_CHUNK;
  localparam int OVERLAP_PIX     = 300;
  localparam int NUM_FRAMES      = 4;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * (`FB_NPIX * 4 + 2000);
  localparam int READY_LIMIT     = `FB_NPIX * 2;

  logic     clk_in;
  logic     arst_n;
  logic     valid_in;
  coord_x_t x;
  coord_y_t y;
  depth_t   z;
  rgb565_t  rgb_in;
  logic     frame_done;
  logic     rdy_out;
  logic     scan_start;
  logic     chunk_tvalid;
  chunk_t   chunk_tdata;
  logic     chunk_tlast;
  logic     chunk_tready;

  // reference model, depth plus both colour banks
  depth_t  model_depth [`FB_NPIX];
  rgb565_t model_color [2][`FB_NPIX];
  logic    model_write_bank;
  logic    scan_bank;

  logic [31:0] lcg_state;
  int          error_count;
  int          pass_count;
  int          fail_count;
  int          chunk_count;
  logic        last_seen;

  framebuffer_top UUT (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .valid_in     (valid_in),
    .x            (x),
    .y            (y),
    .z            (z),
    .rgb_in       (rgb_in),
    .frame_done   (frame_done),
    .rdy_out      (rdy_out),
    .scan_start   (scan_start),
    .chunk_tvalid (chunk_tvalid),
    .chunk_tdata  (chunk_tdata),
    .chunk_tlast  (chunk_tlast),
    .chunk_tready (chunk_tready)
  );

  // 4 ns period
  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // chunk k of the latched display bank, first pixel in the low bits
  function automatic chunk_t expected_chunk(input int k);
    chunk_t c;
    for (int i = 0; i < `FB_PIX_PER_CHUNK; i++) begin
      c[i*16 +: 16] = model_color[scan_bank][k*`FB_PIX_PER_CHUNK + i];
    end
    return c;
  endfunction

  // chunk checker, sampled at the transfer edge
  always @(posedge clk_in) begin
    if (arst_n && chunk_tvalid && chunk_tready) begin
      if (chunk_count >= NCHUNK) begin
        error_count++;
        $display("extra chunk delivered after the last one of the frame");
      end else begin
        if (chunk_tdata !== expected_chunk(chunk_count)) begin
          error_count++;
          $display("[ERROR] chunk %0d chunk_tdata got %h expected %h",
                   chunk_count, chunk_tdata, expected_chunk(chunk_count));
        end
        if (chunk_tlast !== (chunk_count == NCHUNK - 1)) begin
          error_count++;
          $display("[ERROR] chunk %0d chunk_tlast got %h expected %h",
                   chunk_count, chunk_tlast, (chunk_count == NCHUNK - 1));
        end
      end
      chunk_count++;
      if (chunk_tlast) begin
        last_seen = 1'b1;
      end
    end
  end

  // hard stop if anything stalls
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_in);
    $display("timeout after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // one pixel this cycle, model only takes it when the DUT should be ready
  task automatic drive_pixel(input int addr, input depth_t zv, input rgb565_t col,
                             input bit expect_rdy);
    valid_in = 1'b1;
    x        = coord_x_t'(addr % `FB_HRES);
    y        = coord_y_t'(addr / `FB_HRES);
    z        = zv;
    rgb_in   = col;
    if (rdy_out !== expect_rdy) begin
      error_count++;
      $display("[ERROR] rdy_out got %h expected %h at pixel %0d",
               rdy_out, expect_rdy, addr);
    end
    // ties go to the later pixel
    if (expect_rdy && (zv <= model_depth[addr])) begin
      model_depth[addr]                   = zv;
      model_color[model_write_bank][addr] = col;
    end
    @(negedge clk_in);
  endtask

  task automatic idle_cycle();
    valid_in = 1'b0;
    @(negedge clk_in);
  endtask

  task automatic wait_ready(output int cycles);
    cycles = 0;
    while (!rdy_out && cycles < READY_LIMIT) begin
      @(negedge clk_in);
      cycles++;
    end
    if (!rdy_out) begin
      error_count++;
      $display("rdy_out still low after %0d cycles", cycles);
    end
  endtask

  // background everywhere, then random overlaps
  // far selects the upper half of the depth range
  task automatic draw_frame(input bit far);
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] col;
    depth_t      bg_base;
    depth_t      ov_base;
    depth_t      zv;
    depth_t      last_z;
    int          addr;
    int          last_addr;
    bg_base   = far ? 16'hE000 : 16'h6000;
    ov_base   = far ? 16'h8000 : 16'h0000;
    last_addr = 0;
    last_z    = '1;
    for (int a = 0; a < `FB_NPIX; a++) begin
      r   = lcg_next();
      col = lcg_next();
      drive_pixel(a, bg_base | depth_t'(r[28:16]), col[31:16], 1'b1);
    end
    for (int n = 0; n < OVERLAP_PIX; n++) begin
      r   = lcg_next();
      c   = lcg_next();
      col = lcg_next();
      case (r[31:30])
        // back to back, forwarded from one write ago
        2'd2: addr = last_addr;
        // one gap, forwarded from two writes ago
        2'd3: begin
          idle_cycle();
          addr = last_addr;
        end
        default: addr = int'(r[24:16]) % `FB_NPIX;
      endcase
      zv = ov_base | depth_t'(c[30:16]);
      if (c[31] && (addr == last_addr)) begin
        zv = last_z;
      end
      drive_pixel(addr, zv, col[31:16], 1'b1);
      last_addr = addr;
      last_z    = zv;
    end
    idle_cycle();
    idle_cycle();
  endtask

  // swap banks, pixels pushed during the sweep must be dropped
  task automatic swap_frame(input int dropped);
    logic [31:0] r;
    int          cycles;
    valid_in   = 1'b0;
    frame_done = 1'b1;
    @(negedge clk_in);
    frame_done       = 1'b0;
    model_write_bank = ~model_write_bank;
    for (int a = 0; a < `FB_NPIX; a++) begin
      model_depth[a] = '1;
    end
    for (int n = 0; n < dropped; n++) begin
      r = lcg_next();
      drive_pixel(int'(r[24:16]) % `FB_NPIX, 16'h0000, r[31:16], 1'b0);
    end
    valid_in = 1'b0;
    wait_ready(cycles);
    // drain, then one clear write per pixel
    if (dropped + cycles != `FB_NPIX + `FB_RD_LAT) begin
      error_count++;
      $display("rdy_out low for %0d cycles after frame_done, expected %0d",
               dropped + cycles, `FB_NPIX + `FB_RD_LAT);
    end
  endtask

  task automatic scan_frame(input bit backpressure);
    logic [31:0] r;
    scan_bank   = ~model_write_bank;
    chunk_count = 0;
    last_seen   = 1'b0;
    scan_start  = 1'b1;
    @(negedge clk_in);
    scan_start = 1'b0;
    while (!last_seen && chunk_count < NCHUNK) begin
      r            = lcg_next();
      chunk_tready = backpressure ? r[23] : 1'b1;
      @(negedge clk_in);
    end
    chunk_tready = 1'b0;
    if (chunk_count != NCHUNK) begin
      error_count++;
      $display("scan delivered %0d chunks, expected %0d", chunk_count, NCHUNK);
    end
    if (!last_seen) begin
      error_count++;
      $display("scan ended without a chunk marked last");
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      pass_count++;
      $display("PASS  %s", name);
    end else begin
      fail_count++;
      $display("FAIL  %s with %0d errors", name, error_count - errs_before);
    end
  endtask

  initial begin
    int cycles;
    int errs;
    arst_n       = 1'b0;
    valid_in     = 1'b0;
    x            = '0;
    y            = '0;
    z            = '0;
    rgb_in       = '0;
    frame_done   = 1'b0;
    scan_start   = 1'b0;
    chunk_tready = 1'b0;
    lcg_state    = 32'd16;
    error_count  = 0;
    pass_count   = 0;
    fail_count   = 0;
    chunk_count  = 0;
    last_seen    = 1'b0;
    scan_bank    = 1'b0;
    model_write_bank = 1'b0;
    for (int a = 0; a < `FB_NPIX; a++) begin
      model_depth[a] = '1;
    end

    // reset runs the full depth clear first
    errs = error_count;
    repeat (5) @(posedge clk_in);
    @(negedge clk_in);
    if (rdy_out !== 1'b0) begin
      error_count++;
      $display("[ERROR] rdy_out got %h expected 0 during reset", rdy_out);
    end
    if (chunk_tvalid !== 1'b0) begin
      error_count++;
      $display("[ERROR] chunk_tvalid got %h expected 0 during reset", chunk_tvalid);
    end
    arst_n = 1'b1;
    wait_ready(cycles);
    if (cycles != `FB_NPIX) begin
      error_count++;
      $display("rdy_out rose after %0d cycles, expected %0d", cycles, `FB_NPIX);
    end
    report_test("clear_after_reset", errs);

    // near frame into bank 0, then show it
    errs = error_count;
    draw_frame(1'b0);
    swap_frame(0);
    scan_frame(1'b0);
    report_test("depth_test_and_packing", errs);

    // far frame into the hidden bank, display still the old one
    errs = error_count;
    draw_frame(1'b1);
    scan_frame(1'b1);
    report_test("backpressure_old_bank", errs);

    // far depths only land if the clear happened
    errs = error_count;
    swap_frame(100);
    scan_frame(1'b0);
    report_test("depth_clear_and_swap", errs);

    // pixels sent during the last sweep must not show in this frame
    errs = error_count;
    draw_frame(1'b0);
    swap_frame(100);
    scan_frame(1'b1);
    report_test("dropped_pixels", errs);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
